// File: hw/msgst_addr_gen.sv
`timescale 1ns/10ps
`include "msgst_config.svh"

module msgst_addr_gen
    import msgst_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run_start_i,
    input  logic                     ctrl_load_i,
    input  logic                     pkt_done_i,
    input  logic [`MSGST_REQ_W-1:0]  req_cnt_i,
    input  logic [4:0]               cmd_dst_id_i,
    input  logic [`MSGST_LEN_W-1:0]  cmd_len_i,
    input  logic [`MSGST_ADDR_W-1:0] pci_host_addr_i,
    input  logic [`MSGST_ADDR_W-1:0] pci_host_addr_mask_i,
    input  logic [`MSGST_ADDR_W-1:0] psx_host_addr_i,
    input  logic [`MSGST_ADDR_W-1:0] psx_host_addr_mask_i,
    input  logic [1:0]               num_of_noc_cfg_i,
    input  logic [6:0]               noc_switch_req_cnt_i,
    output logic [`MSGST_ADDR_W-1:0] msg_addr_o
);

    dest_t                    dest_q;
    dest_t                    dest_nxt;
    logic [`MSGST_ADDR_W-1:0] pci_base_q;
    logic [`MSGST_ADDR_W-1:0] pci_mask_q;
    logic [`MSGST_ADDR_W-1:0] psx_base_q;
    logic [`MSGST_ADDR_W-1:0] psx_mask_q;
    logic [`MSGST_ADDR_W-1:0] host_addr_q;
    logic [5:0]               ap_id_q;
    logic [`MSGST_REQ_W-1:0]  req_cnt_nxt;

    assign req_cnt_nxt = req_cnt_i + 1'b1;

    always_comb begin
        case (cmd_dst_id_i)
            5'd4, 5'd5, 5'd6, 5'd7: dest_nxt = DEST_HOST;
            5'd12:                  dest_nxt = DEST_PSX;
            default:                dest_nxt = DEST_NONE;
        endcase
    end

    // bases and masks sampled once per run
    always_ff @(posedge clk) begin
        if (run_start_i) begin
            pci_base_q <= pci_host_addr_i;
            pci_mask_q <= pci_host_addr_mask_i;
            psx_base_q <= psx_host_addr_i;
            psx_mask_q <= psx_host_addr_mask_i;
        end
        if (ctrl_load_i && (req_cnt_i == '0) && (dest_nxt == DEST_HOST)) begin
            host_addr_q <= pci_base_q;
        end else if (ctrl_load_i && (req_cnt_i == '0) && (dest_nxt == DEST_PSX)) begin
            host_addr_q <= psx_base_q;
        end else if (pkt_done_i) begin
            host_addr_q <= host_addr_q + `MSGST_ADDR_W'(cmd_len_i);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dest_q  <= DEST_NONE;
            ap_id_q <= 6'd0;
        end else begin
            if (ctrl_load_i) begin
                dest_q <= dest_nxt;
            end
            // NoC port rotation, modulo cfg plus one
            if (run_start_i) begin
                ap_id_q <= 6'd0;
            end else if (pkt_done_i && (req_cnt_nxt[6:0] == noc_switch_req_cnt_i)) begin
                ap_id_q <= (ap_id_q >= {4'd0, num_of_noc_cfg_i}) ? 6'd0 : ap_id_q + 6'd1;
            end
        end
    end

    always_comb begin
        case (dest_q)
            DEST_HOST: msg_addr_o = {pci_mask_q[63:12], host_addr_q[11:0]};
            DEST_PSX:  msg_addr_o = {ap_id_q, psx_mask_q[57:12], host_addr_q[11:0]};
            default:   msg_addr_o = '0;
        endcase
    end

endmodule

// File: hw/msgst_beat_gen.sv
`timescale 1ns/10ps
`include "msgst_config.svh"

module msgst_beat_gen
    import msgst_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ctrl_load_i,
    input  logic                   beat_acc_i,
    input  logic [`MSGST_LEN_W-1:0] cmd_len_i,
    input  logic [7:0]             cmd_seed_i,
    input  logic [4:0]             cmd_offset_i,
    output beat_t                  msg_dat_o,
    output logic                   last_beat_o
);

    localparam int BEAT  = `MSGST_BEAT_BYTES;
    localparam int REM_W = `MSGST_REM_W;

    logic [REM_W-1:0] rem_q;
    logic [7:0]       seq_q;
    logic             first_q;
    logic             active_q;
    logic [31:0]      pkt_id_q;
    // live byte limit within this beat
    logic [5:0]       lim;
    logic [4:0]       off_eff;
    beat_t            raw;

    assign lim         = (rem_q > BEAT) ? 6'(BEAT) : rem_q[5:0];
    assign off_eff     = first_q ? cmd_offset_i : 5'd0;
    assign last_beat_o = active_q && (rem_q <= BEAT);

    // sequential bytes, zero outside the live window
    always_comb begin
        for (int i = 0; i < BEAT; i++) begin
            if ((i < lim) && (i >= off_eff)) begin
                raw[i] = seq_q + 8'(i) - 8'(off_eff);
            end else begin
                raw[i] = 8'h00;
            end
        end
    end

    // header on the first beat, check byte on every beat
    always_comb begin
        msg_dat_o = raw;
        if (first_q) begin
            msg_dat_o[0] = cmd_len_i[7:0];
            for (int h = 1; h < `MSGST_HDR_BYTES; h++) begin
                msg_dat_o[h] = pkt_id_q[8*(h-1) +: 8];
            end
        end
        msg_dat_o[BEAT-1] = msg_dat_o[1] ^ msg_dat_o[7] ^ msg_dat_o[10] ^ msg_dat_o[13] ^
                            msg_dat_o[17] ^ msg_dat_o[21] ^ msg_dat_o[26] ^ msg_dat_o[30];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rem_q    <= '0;
            first_q  <= 1'b0;
            active_q <= 1'b0;
            pkt_id_q <= '0;
        end else if (ctrl_load_i) begin
            rem_q    <= REM_W'(cmd_len_i) + REM_W'(cmd_offset_i);
            first_q  <= 1'b1;
            active_q <= 1'b1;
        end else if (beat_acc_i) begin
            rem_q   <= rem_q - REM_W'(BEAT);
            first_q <= 1'b0;
            if (last_beat_o) begin
                active_q <= 1'b0;
                pkt_id_q <= pkt_id_q + 1'b1;
            end
        end
    end

    // next beat continues after the last live byte
    always_ff @(posedge clk) begin
        if (ctrl_load_i) begin
            seq_q <= cmd_seed_i;
        end else if (beat_acc_i) begin
            seq_q <= seq_q + 8'(lim) - 8'(off_eff);
        end
    end

endmodule

// File: hw/msgst_cmd_fetch.sv
`timescale 1ns/10ps
`include "msgst_config.svh"

module msgst_cmd_fetch (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run_start_i,
    input  logic                     fetch_start_i,
    input  logic [31:0]              cmd_ram_din_i,
    output logic                     cmd_ram_ren_o,
    output logic [`MSGST_CMD_AW-1:0] cmd_ram_addr_o,
    output logic                     cmd_valid_o,
    output logic [`MSGST_LEN_W-1:0]  cmd_len_o,
    output logic [1:0]               cmd_op_o,
    output logic [7:0]               cmd_seed_o,
    output logic [4:0]               cmd_dst_id_o,
    output logic [4:0]               cmd_offset_o
);

    logic [`MSGST_CMD_AW-1:0] rec_base_q;
    logic [`MSGST_CMD_AW-1:0] rec_next;
    // 1 = word 0 read, 2 = word 1 read
    logic [1:0]               rd_step_q;
    // read step seen one cycle later, lines up with returned data
    logic [1:0]               rd_land_q;

    assign rec_next = rec_base_q + `MSGST_CMD_AW'(`MSGST_CMD_STRIDE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_step_q   <= 2'd0;
            rd_land_q   <= 2'd0;
            rec_base_q  <= '0;
            cmd_valid_o <= 1'b0;
        end else begin
            if (fetch_start_i) begin
                rd_step_q <= 2'd1;
            end else if (rd_step_q == 2'd1) begin
                rd_step_q <= 2'd2;
            end else begin
                rd_step_q <= 2'd0;
            end
            rd_land_q   <= rd_step_q;
            cmd_valid_o <= (rd_land_q == 2'd2);
            if (run_start_i) begin
                rec_base_q <= '0;
            end else if (rd_step_q == 2'd2) begin
                rec_base_q <= (rec_next == `MSGST_CMD_WRAP) ? '0 : rec_next;
            end
        end
    end

    // field registers
    always_ff @(posedge clk) begin
        if (rd_land_q == 2'd1) begin
            cmd_len_o <= cmd_ram_din_i[`MSGST_W0_LEN];
            cmd_op_o  <= cmd_ram_din_i[`MSGST_W0_OP];
        end
        if (rd_land_q == 2'd2) begin
            cmd_seed_o   <= cmd_ram_din_i[`MSGST_W1_SEED];
            cmd_dst_id_o <= cmd_ram_din_i[`MSGST_W1_DST];
            cmd_offset_o <= cmd_ram_din_i[`MSGST_W1_OFFSET];
        end
    end

    assign cmd_ram_ren_o  = (rd_step_q != 2'd0);
    // record base is 8-byte aligned, second word sits at +4
    assign cmd_ram_addr_o = {rec_base_q[`MSGST_CMD_AW-1:3], rd_step_q[1], 2'b00};

endmodule

// File: hw/msgst_config.svh
`ifndef MSGST_CONFIG_SVH
`define MSGST_CONFIG_SVH

// beat and field sizes
`define MSGST_BEAT_BYTES 32
`define MSGST_LEN_W      9
`define MSGST_REM_W      10
`define MSGST_REQ_W      15
`define MSGST_ADDR_W     64

// command RAM layout, two 32-bit words per record
`define MSGST_CMD_AW     16
`define MSGST_CMD_STRIDE 8
`define MSGST_CMD_WRAP   16'h0080
`define MSGST_HDR_BYTES  5

// word 0 fields
`define MSGST_W0_LEN     8:0
`define MSGST_W0_OP      10:9
// word 1 fields
`define MSGST_W1_SEED    7:0
`define MSGST_W1_DST     26:22
`define MSGST_W1_OFFSET  31:27

`endif

// File: hw/msgst_ctrl_fsm.sv
`timescale 1ns/10ps
`include "msgst_config.svh"

module msgst_ctrl_fsm
    import msgst_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pld_cmd_req_i,
    input  logic [`MSGST_REQ_W-1:0] num_of_reqs_i,
    input  logic                    cmd_valid_i,
    input  logic                    last_beat_i,
    input  logic                    msg_rdy_i,
    output logic                    run_start_o,
    output logic                    fetch_start_o,
    output logic                    ctrl_load_o,
    output logic                    beat_acc_o,
    output logic                    pkt_done_o,
    output logic [`MSGST_REQ_W-1:0] req_cnt_o,
    output logic                    msg_vld_o,
    output logic                    req_done_o
);

    msgst_state_t            state_q;
    msgst_state_t            state_nxt;
    logic                    req_ff_q;
    logic [`MSGST_REQ_W-1:0] req_cnt_q;
    logic [`MSGST_REQ_W-1:0] req_cnt_nxt;
    logic                    run_done;

    // rising edge of the request, honoured only when idle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_ff_q <= 1'b0;
        end else begin
            req_ff_q <= pld_cmd_req_i;
        end
    end

    assign run_start_o = pld_cmd_req_i && !req_ff_q && (state_q == IDLE);

    assign req_cnt_nxt = req_cnt_q + 1'b1;
    assign run_done    = (req_cnt_nxt == num_of_reqs_i);

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            IDLE: begin
                if (run_start_o && (num_of_reqs_i != '0)) begin
                    state_nxt = FETCH;
                end
            end
            FETCH: begin
                if (cmd_valid_i) begin
                    state_nxt = CTRL;
                end
            end
            CTRL: begin
                state_nxt = DATA;
            end
            DATA: begin
                if (pkt_done_o) begin
                    state_nxt = run_done ? IDLE : FETCH;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= IDLE;
            req_cnt_q <= '0;
        end else begin
            state_q <= state_nxt;
            if (run_start_o) begin
                req_cnt_q <= '0;
            end else if (pkt_done_o) begin
                req_cnt_q <= req_cnt_nxt;
            end
        end
    end

    // one pulse on every entry into FETCH
    assign fetch_start_o = (state_nxt == FETCH) && (state_q != FETCH);
    assign ctrl_load_o   = (state_q == CTRL);
    assign msg_vld_o     = (state_q == DATA);
    assign beat_acc_o    = msg_vld_o && msg_rdy_i;
    assign pkt_done_o    = beat_acc_o && last_beat_i;
    assign req_cnt_o     = req_cnt_q;
    assign req_done_o    = (req_cnt_q == num_of_reqs_i) && (num_of_reqs_i != '0);

endmodule

// File: hw/msgst_engine.sv
`timescale 1ns/10ps
`include "msgst_config.svh"

module msgst_engine
    import msgst_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pld_cmd_req_i,
    input  logic [`MSGST_REQ_W-1:0]  num_of_reqs_i,
    input  logic [`MSGST_ADDR_W-1:0] pci_host_addr_i,
    input  logic [`MSGST_ADDR_W-1:0] pci_host_addr_mask_i,
    input  logic [`MSGST_ADDR_W-1:0] psx_host_addr_i,
    input  logic [`MSGST_ADDR_W-1:0] psx_host_addr_mask_i,
    input  logic [1:0]               num_of_noc_cfg_i,
    input  logic [6:0]               noc_switch_req_cnt_i,
    input  logic [31:0]              cmd_ram_din_i,
    output logic                     cmd_ram_ren_o,
    output logic [`MSGST_CMD_AW-1:0] cmd_ram_addr_o,
    output logic                     msg_vld_o,
    input  logic                     msg_rdy_i,
    output beat_t                    msg_dat_o,
    output logic                     msg_eop_o,
    output logic [`MSGST_LEN_W-1:0]  msg_len_o,
    output logic [1:0]               msg_op_o,
    output logic [`MSGST_ADDR_W-1:0] msg_addr_o,
    output logic                     req_done_o
);

    logic                    run_start;
    logic                    fetch_start;
    logic                    cmd_valid;
    logic                    ctrl_load;
    logic                    beat_acc;
    logic                    pkt_done;
    logic [`MSGST_REQ_W-1:0] req_cnt;
    logic [7:0]              cmd_seed;
    logic [4:0]              cmd_dst_id;
    logic [4:0]              cmd_offset;

    // length and opcode go straight from the held command fields
    msgst_cmd_fetch i_msgst_cmd_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .run_start_i   (run_start),
        .fetch_start_i (fetch_start),
        .cmd_ram_din_i (cmd_ram_din_i),
        .cmd_ram_ren_o (cmd_ram_ren_o),
        .cmd_ram_addr_o(cmd_ram_addr_o),
        .cmd_valid_o   (cmd_valid),
        .cmd_len_o     (msg_len_o),
        .cmd_op_o      (msg_op_o),
        .cmd_seed_o    (cmd_seed),
        .cmd_dst_id_o  (cmd_dst_id),
        .cmd_offset_o  (cmd_offset)
    );

    msgst_ctrl_fsm i_msgst_ctrl_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .pld_cmd_req_i(pld_cmd_req_i),
        .num_of_reqs_i(num_of_reqs_i),
        .cmd_valid_i  (cmd_valid),
        .last_beat_i  (msg_eop_o),
        .msg_rdy_i    (msg_rdy_i),
        .run_start_o  (run_start),
        .fetch_start_o(fetch_start),
        .ctrl_load_o  (ctrl_load),
        .beat_acc_o   (beat_acc),
        .pkt_done_o   (pkt_done),
        .req_cnt_o    (req_cnt),
        .msg_vld_o    (msg_vld_o),
        .req_done_o   (req_done_o)
    );

    // eop is the last-beat level
    msgst_beat_gen i_msgst_beat_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl_load_i (ctrl_load),
        .beat_acc_i  (beat_acc),
        .cmd_len_i   (msg_len_o),
        .cmd_seed_i  (cmd_seed),
        .cmd_offset_i(cmd_offset),
        .msg_dat_o   (msg_dat_o),
        .last_beat_o (msg_eop_o)
    );

    msgst_addr_gen i_msgst_addr_gen (
        .clk                 (clk),
        .rst_n               (rst_n),
        .run_start_i         (run_start),
        .ctrl_load_i         (ctrl_load),
        .pkt_done_i          (pkt_done),
        .req_cnt_i           (req_cnt),
        .cmd_dst_id_i        (cmd_dst_id),
        .cmd_len_i           (msg_len_o),
        .pci_host_addr_i     (pci_host_addr_i),
        .pci_host_addr_mask_i(pci_host_addr_mask_i),
        .psx_host_addr_i     (psx_host_addr_i),
        .psx_host_addr_mask_i(psx_host_addr_mask_i),
        .num_of_noc_cfg_i    (num_of_noc_cfg_i),
        .noc_switch_req_cnt_i(noc_switch_req_cnt_i),
        .msg_addr_o          (msg_addr_o)
    );

endmodule

// File: hw/msgst_pkg.sv
`include "msgst_config.svh"

package msgst_pkg;

    // packet sequencing states
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        CTRL,
        DATA
    } msgst_state_t;

    // one stream beat, byte 0 in the low lanes
    typedef logic [`MSGST_BEAT_BYTES-1:0][7:0] beat_t;

    // target class decoded from the destination id
    typedef enum logic [1:0] {
        DEST_NONE,
        DEST_HOST,
        DEST_PSX
    } dest_t;

endpackage

// File: list.f
+incdir+hw
hw/msgst_pkg.sv
hw/msgst_cmd_fetch.sv
hw/msgst_ctrl_fsm.sv
hw/msgst_beat_gen.sv
hw/msgst_addr_gen.sv
hw/msgst_engine.sv
tb/msgst_engine_chk.sv
tb/msgst_engine_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module msgst_engine_tb -f list.f -o msgst_sim

sim_out=$(./obj_dir/msgst_sim) || true
echo "$sim_out"

if grep -qx "test passed" <<< "$sim_out"; then
    exit 0
fi
exit 1

// File: tb/msgst_cases.txt
// columns, all hex: case id, num_of_reqs, noc cfg, switch count, dest class, stall percent
// dest class 0 none, 1 host, 2 psx, 3 mixed
01 0005 0 02 1 00 // short host run without stalls
02 0014 1 03 2 14 // psx run past the command wrap
03 0003 0 01 0 1e // none destination, address stays zero
04 0104 1 05 2 0a // long psx run, ap_id wraps back
05 0018 2 04 3 32 // mixed destinations under heavy stall
06 0010 3 02 2 28 // four NoC ports

// File: tb/msgst_engine_chk.sv
`timescale 1ns/10ps
`include "msgst_config.svh"

module msgst_engine_chk
    import msgst_pkg::*;
(
    input logic                     clk,
    input logic                     rst_n,
    input logic                     vld_i,
    input logic                     rdy_i,
    input beat_t                    dat_i,
    input logic                     eop_i,
    input logic [`MSGST_LEN_W-1:0]  len_i,
    input logic [1:0]               op_i,
    input logic [`MSGST_ADDR_W-1:0] addr_i,
    input logic                     ren_i
);

    // a stalled beat must be presented again unchanged
    a_hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        (vld_i && !rdy_i) |=> (vld_i && $stable(dat_i) && $stable(eop_i) && $stable(len_i)
                               && $stable(op_i) && $stable(addr_i)))
        else $error("message outputs changed while the sink stalled");

    // command reads come in bursts of exactly two
    a_ren_burst: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ren_i) |=> ren_i ##1 !ren_i)
        else $error("command read burst was not exactly two cycles long");

endmodule

bind msgst_engine msgst_engine_chk i_msgst_engine_chk (
    .clk   (clk),
    .rst_n (rst_n),
    .vld_i (msg_vld_o),
    .rdy_i (msg_rdy_i),
    .dat_i (msg_dat_o),
    .eop_i (msg_eop_o),
    .len_i (msg_len_o),
    .op_i  (msg_op_o),
    .addr_i(msg_addr_o),
    .ren_i (cmd_ram_ren_o)
);

// File: tb/msgst_engine_tb.sv
`timescale 1ns/10ps
`include "msgst_config.svh"

module msgst_engine_tb
    import msgst_pkg::*;
();

    logic                     clk;
    logic                     rst_n;
    logic                     pld_cmd_req;
    logic [`MSGST_REQ_W-1:0]  num_of_reqs;
    logic [`MSGST_ADDR_W-1:0] pci_addr;
    logic [`MSGST_ADDR_W-1:0] pci_mask;
    logic [`MSGST_ADDR_W-1:0] psx_addr;
    logic [`MSGST_ADDR_W-1:0] psx_mask;
    logic [1:0]               noc_cfg;
    logic [6:0]               switch_cnt;
    logic [31:0]              cmd_din;
    logic                     ren;
    logic [`MSGST_CMD_AW-1:0] cmd_addr;
    logic                     vld;
    logic                     rdy;
    beat_t                    dat;
    logic                     eop;
    logic [`MSGST_LEN_W-1:0]  len;
    logic [1:0]               op;
    logic [`MSGST_ADDR_W-1:0] addr;
    logic                     req_done;

    // command RAM model with 16 records of two words
    logic [31:0] cmd_mem [0:31];
    logic        rd_pend;
    logic [4:0]  rd_word;
    logic [8:0]  rec_len [0:15];
    logic [1:0]  rec_op [0:15];
    logic [7:0]  rec_seed [0:15];
    logic [4:0]  rec_dst [0:15];
    logic [4:0]  rec_off [0:15];

    logic [15:0] case_mem [0:47];
    integer      seed = 31067;
    string       test_name;
    int          ren_cnt;
    int          wd_cycles;
    logic [31:0] pkt_id;

    msgst_engine i_msgst_engine (
        .clk                 (clk),
        .rst_n               (rst_n),
        .pld_cmd_req_i       (pld_cmd_req),
        .num_of_reqs_i       (num_of_reqs),
        .pci_host_addr_i     (pci_addr),
        .pci_host_addr_mask_i(pci_mask),
        .psx_host_addr_i     (psx_addr),
        .psx_host_addr_mask_i(psx_mask),
        .num_of_noc_cfg_i    (noc_cfg),
        .noc_switch_req_cnt_i(switch_cnt),
        .cmd_ram_din_i       (cmd_din),
        .cmd_ram_ren_o       (ren),
        .cmd_ram_addr_o      (cmd_addr),
        .msg_vld_o           (vld),
        .msg_rdy_i           (rdy),
        .msg_dat_o           (dat),
        .msg_eop_o           (eop),
        .msg_len_o           (len),
        .msg_op_o            (op),
        .msg_addr_o          (addr),
        .req_done_o          (req_done)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic end_in_failure();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [255:0] exp_v,
                               input logic [255:0] act_v);
        if (act_v !== exp_v) begin
            $display("Error: %s %s expected %h actual %h", test_name, what, exp_v, act_v);
            end_in_failure();
        end
    endtask

    // serve the command RAM on the falling edge one cycle after ren
    task automatic next_cycle();
        int exp_a;
        @(negedge clk);
        cmd_din = rd_pend ? cmd_mem[rd_word] : 32'h0;
        if (ren) begin
            exp_a = ((ren_cnt / 2) % 16) * 8 + (ren_cnt % 2) * 4;
            check_value("command address", 256'(exp_a), 256'(cmd_addr));
            ren_cnt++;
        end
        rd_pend = ren;
        rd_word = cmd_addr[6:2];
    endtask

    task automatic fill_commands(input int dclass);
        int         r;
        int         pick;
        logic [4:0] dst;
        for (r = 0; r < 16; r++) begin
            pick = {$random(seed)} % 4;
            case (dclass)
                0: dst = 5'(16 + pick);
                1: dst = 5'(4 + pick);
                2: dst = 5'd12;
                default: begin
                    case (pick)
                        0: dst = 5'd13;
                        1: dst = 5'd5;
                        2: dst = 5'd12;
                        default: dst = 5'd0;
                    endcase
                    // first packet of a run must load the host address
                    if (r == 0) dst = 5'd6;
                end
            endcase
            if (r % 4 == 0) begin
                rec_len[r] = 9'(({$random(seed)} % 7) * 32);
            end else begin
                rec_len[r] = 9'({$random(seed)} % 201);
            end
            rec_off[r]  = 5'($random(seed));
            rec_op[r]   = 2'($random(seed));
            rec_seed[r] = 8'($random(seed));
            rec_dst[r]  = dst;
            if (r == 4) rec_len[r] = 9'd0;
            if (r == 8) begin
                rec_len[r] = 9'd32;
                rec_off[r] = 5'd0;
            end
            cmd_mem[2*r]   = {21'($random(seed)), rec_op[r], rec_len[r]};
            cmd_mem[2*r+1] = {rec_off[r], rec_dst[r], 14'($random(seed)), rec_seed[r]};
        end
    endtask

    task automatic predict_beat(input int rem, input logic [7:0] seq, input bit first,
                                input int rec, output beat_t b, output logic [7:0] seq_next);
        int i;
        int lim;
        int start;
        lim   = (rem < 32) ? rem : 32;
        start = first ? int'(rec_off[rec]) : 0;
        for (i = 0; i < 32; i++) begin
            b[i] = (i >= start && i < lim) ? seq + 8'(i - start) : 8'h00;
        end
        if (first) begin
            b[0] = rec_len[rec][7:0];
            b[1] = pkt_id[7:0];
            b[2] = pkt_id[15:8];
            b[3] = pkt_id[23:16];
            b[4] = pkt_id[31:24];
        end
        b[31]    = b[1] ^ b[7] ^ b[10] ^ b[13] ^ b[17] ^ b[21] ^ b[26] ^ b[30];
        seq_next = seq + 8'(lim - start);
    endtask

    function automatic logic [63:0] expected_address(input logic [4:0] id,
                                                     input logic [63:0] host_a, input int ap);
        if (id >= 5'd4 && id <= 5'd7) return {pci_mask[63:12], host_a[11:0]};
        if (id == 5'd12) return {6'(ap), psx_mask[57:12], host_a[11:0]};
        return 64'h0;
    endfunction

    task automatic run_case(input int c);
        int          n;
        int          stall;
        int          p;
        int          rec;
        int          rem;
        int          ap;
        bit          first;
        bit          new_pkt;
        logic [7:0]  seq;
        logic [7:0]  seq_next;
        logic [63:0] host_a;
        logic [63:0] exp_addr;
        beat_t       exp_b;
        test_name = $sformatf("case_%02h", case_mem[6*c]);
        n         = int'(case_mem[6*c+1]);
        stall     = int'(case_mem[6*c+5]);
        fill_commands(int'(case_mem[6*c+4]));
        ren_cnt     = 0;
        p           = 0;
        ap          = 0;
        host_a      = 64'h0;
        new_pkt     = 1'b1;
        num_of_reqs = 15'(n);
        noc_cfg     = case_mem[6*c+2][1:0];
        switch_cnt  = case_mem[6*c+3][6:0];
        pci_addr    = {$random(seed), $random(seed)};
        pci_mask    = {$random(seed), $random(seed)};
        psx_addr    = {$random(seed), $random(seed)};
        psx_mask    = {$random(seed), $random(seed)};
        pld_cmd_req = 1'b1;
        while (p < n) begin
            next_cycle();
            pld_cmd_req = 1'b0;
            check_value("req_done", 256'(0), 256'(req_done));
            if (new_pkt) begin
                rec   = p % 16;
                rem   = int'(rec_len[rec]) + int'(rec_off[rec]);
                seq   = rec_seed[rec];
                first = 1'b1;
                if (p == 0 && rec_dst[rec] >= 5'd4 && rec_dst[rec] <= 5'd7) host_a = pci_addr;
                if (p == 0 && rec_dst[rec] == 5'd12) host_a = psx_addr;
                exp_addr = expected_address(rec_dst[rec], host_a, ap);
                new_pkt  = 1'b0;
            end
            rdy = ({$random(seed)} % 100) >= stall;
            if (vld && rdy) begin
                predict_beat(rem, seq, first, rec, exp_b, seq_next);
                check_value("data", 256'(exp_b), 256'(dat));
                check_value("eop", 256'(rem <= 32), 256'(eop));
                check_value("length", 256'(rec_len[rec]), 256'(len));
                check_value("opcode", 256'(rec_op[rec]), 256'(op));
                check_value("address", 256'(exp_addr), 256'(addr));
                seq   = seq_next;
                first = 1'b0;
                if (rem <= 32) begin
                    pkt_id++;
                    p++;
                    host_a = host_a + 64'(rec_len[rec]);
                    if (7'(p) == switch_cnt) ap = (ap + 1) % (int'(noc_cfg) + 1);
                    new_pkt = 1'b1;
                end else begin
                    rem -= 32;
                end
            end
        end
        // engine back in IDLE with done raised after the last eop
        next_cycle();
        check_value("req_done after run", 256'(1), 256'(req_done));
        check_value("vld after run", 256'(0), 256'(vld));
        check_value("ren after run", 256'(0), 256'(ren));
        check_value("eop after run", 256'(0), 256'(eop));
    endtask

    initial begin
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge clk);
        $display("watchdog: the run did not finish within %0d cycles", wd_cycles);
        end_in_failure();
    end

    initial begin
        int c;
        int n_cases;
        int total;
        rst_n       = 1'b0;
        pld_cmd_req = 1'b0;
        num_of_reqs = '0;
        pci_addr    = '0;
        pci_mask    = '0;
        psx_addr    = '0;
        psx_mask    = '0;
        noc_cfg     = 2'd0;
        switch_cnt  = 7'd0;
        cmd_din     = 32'h0;
        rdy         = 1'b0;
        rd_pend     = 1'b0;
        rd_word     = 5'd0;
        pkt_id      = 32'h0;
        wd_cycles   = 0;
        for (c = 0; c < 48; c++) begin
            case_mem[c] = 16'h0;
        end
        $readmemh("tb/msgst_cases.txt", case_mem);
        n_cases = 0;
        total   = 500;
        // up to 8 beats per packet and 20 cycles per beat
        while (n_cases < 8 && case_mem[6*n_cases+1] != 16'h0) begin
            total += int'(case_mem[6*n_cases+1]) * 8 * 20;
            n_cases++;
        end
        if (n_cases == 0) begin
            $display("no test cases were read from tb/msgst_cases.txt");
            end_in_failure();
        end
        wd_cycles = total;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        next_cycle();
        test_name = "after_reset";
        check_value("vld", 256'(0), 256'(vld));
        check_value("ren", 256'(0), 256'(ren));
        check_value("eop", 256'(0), 256'(eop));
        check_value("req_done", 256'(0), 256'(req_done));
        for (c = 0; c < n_cases; c++) begin
            run_case(c);
        end
        $display("test passed");
        $finish;
    end

endmodule
